/* bender.yml */
package:
  name: vec_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/vec_pkg.sv
      - source/vec_regfile.sv
      - source/vec_alu.sv
      - source/vec_apb_ctrl.sv
      - source/vec_unit_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_vec_unit.sv

/* include/vec_regmap.svh */
// vector unit APB register map and command word field positions
`ifndef VEC_REGMAP_SVH
`define VEC_REGMAP_SVH

`define REG_STAGE0 8'h00       // staging word 0, least significant
`define REG_STAGE1 8'h04
`define REG_STAGE2 8'h08
`define REG_STAGE3 8'h0C       // staging word 3, most significant
`define REG_COMMIT 8'h10       // wdata holds target register
`define REG_RDSEL  8'h14       // readback register select
`define REG_CMD    8'h18       // vector op issue
`define REG_READ0  8'h20       // readback words, read only
`define REG_READ1  8'h24
`define REG_READ2  8'h28
`define REG_READ3  8'h2C

`define CMD_VD_LSB       0     // bits 5:0
`define CMD_VS1_LSB      8     // bits 13:8
`define CMD_VS2_LSB      16    // bits 21:16
`define CMD_OP_LSB       24    // bits 25:24
`define CMD_USE_MASK_BIT 28
`define VEC_MASK_REG     0     // mask always comes from v0

`endif

/* source/vec_alu.sv */
// two-stage masked element-wise vector ALU, writes back through port 0
`timescale 1ns/100ps

module vec_alu
    import vec_pkg::*;
#(
    parameter int  NUM_PREGS = DEF_NUM_PREGS,
    localparam int AW        = $clog2(NUM_PREGS)
) (
    input  logic          clk_i,
    input  logic          rst_i,
    // issue side
    input  logic          issue_i,
    input  alu_op_t       op_i,
    input  logic [AW-1:0] vd_i,
    input  logic          use_mask_i,
    input  vreg_data_t    src1_i,
    input  vreg_data_t    src2_i,
    input  vreg_data_t    old_vd_i,
    input  vmask_t        mask_i,
    // write-back
    output logic          wb_en_o,
    output logic [AW-1:0] wb_addr_o,
    output vreg_data_t    wb_data_o
);

    // stage 1 holds operands
    logic          s1_valid;
    alu_op_t       s1_op;
    logic [AW-1:0] s1_vd;
    vmask_t        s1_mask;
    vreg_data_t    s1_src1;
    vreg_data_t    s1_src2;
    vreg_data_t    s1_old;
    vreg_data_t    s1_result;

    // stage 2 holds the result
    logic          s2_valid;
    logic [AW-1:0] s2_vd;
    vreg_data_t    s2_data;

    function automatic elem_t elem_op(input alu_op_t op, input elem_t a, input elem_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            default: return a ^ b;
        endcase
    endfunction

    always_comb begin
        for (int i = 0; i < NUM_ELEM; i++) begin
            s1_result[i*ELEM_W +: ELEM_W] = s1_mask[i] ?
                elem_op(s1_op, s1_src1[i*ELEM_W +: ELEM_W], s1_src2[i*ELEM_W +: ELEM_W]) :
                s1_old[i*ELEM_W +: ELEM_W];   // masked-off lane keeps old vd
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= issue_i;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_i) begin
            s1_op   <= op_i;
            s1_vd   <= vd_i;
            s1_mask <= use_mask_i ? mask_i : '1;
            s1_src1 <= src1_i;
            s1_src2 <= src2_i;
            s1_old  <= old_vd_i;
        end
        if (s1_valid) begin
            s2_vd   <= s1_vd;
            s2_data <= s1_result;
        end
    end

    assign wb_en_o   = s2_valid;
    assign wb_addr_o = s2_vd;
    assign wb_data_o = s2_data;

endmodule

/* source/vec_apb_ctrl.sv */
// APB slave for the vector unit holding staging, commit, readback and op issue
`timescale 1ns/100ps

`include "vec_regmap.svh"

module vec_apb_ctrl
    import vec_pkg::*;
#(
    parameter int  NUM_PREGS = DEF_NUM_PREGS,
    localparam int AW        = $clog2(NUM_PREGS)
) (
    input  logic          clk_i,
    input  logic          rst_i,
    // APB slave
    input  logic          psel_i,
    input  logic          penable_i,
    input  logic          pwrite_i,
    input  logic [7:0]    paddr_i,
    input  apb_word_t     pwdata_i,
    output apb_word_t     prdata_o,
    output logic          pready_o,
    output logic          pslverr_o,
    // register file read addresses
    output logic [AW-1:0] rd_addr1_o,
    output logic [AW-1:0] rd_addr2_o,
    output logic [AW-1:0] rd_addr_old_vd_o,
    output logic [AW-1:0] rd_addrm_o,
    output logic          use_mask_o,
    input  vreg_data_t    rd_data1_i,
    // commit write, port 1
    output logic          commit_en_o,
    output logic [AW-1:0] commit_addr_o,
    output vreg_data_t    commit_data_o,
    // issue to ALU
    output logic          issue_o,
    output alu_op_t       op_o,
    output logic [AW-1:0] vd_o
);

    logic          access;
    logic          wr_hit;      // offset is writable
    logic          rd_hit;      // offset is readable
    logic          stage_wr;
    logic          rdsel_wr;
    apb_word_t     stage_q [4];
    logic [AW-1:0] rdsel_q;

    assign access = psel_i && penable_i;

    // only the READ words are readable and everything else is write only
    always_comb begin
        wr_hit = 1'b0;
        rd_hit = 1'b0;
        case (paddr_i)
            `REG_STAGE0, `REG_STAGE1, `REG_STAGE2, `REG_STAGE3,
            `REG_COMMIT, `REG_RDSEL, `REG_CMD: wr_hit = 1'b1;
            `REG_READ0, `REG_READ1, `REG_READ2, `REG_READ3: rd_hit = 1'b1;
            default: begin
                wr_hit = 1'b0;
                rd_hit = 1'b0;
            end
        endcase
    end

    assign pready_o  = 1'b1;   // zero wait states
    assign pslverr_o = access && (pwrite_i ? !wr_hit : !rd_hit);

    // 0x00..0x0C, aligned offsets only
    assign stage_wr    = access && pwrite_i && wr_hit && (paddr_i[7:4] == 4'h0);
    assign rdsel_wr    = access && pwrite_i && (paddr_i == `REG_RDSEL);
    assign commit_en_o = access && pwrite_i && (paddr_i == `REG_COMMIT);
    assign issue_o     = access && pwrite_i && (paddr_i == `REG_CMD);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < 4; i++) begin
                stage_q[i] <= '0;
            end
            rdsel_q <= '0;
        end else begin
            if (stage_wr) begin
                stage_q[paddr_i[3:2]] <= pwdata_i;
            end
            if (rdsel_wr) begin
                rdsel_q <= pwdata_i[AW-1:0];
            end
        end
    end

    // stage0 is least significant
    assign commit_addr_o = pwdata_i[AW-1:0];
    assign commit_data_o = {stage_q[3], stage_q[2], stage_q[1], stage_q[0]};

    // command fields are only meaningful while issue_o is high
    assign op_o = pwdata_i[`CMD_OP_LSB +: 2];
    assign vd_o = pwdata_i[`CMD_VD_LSB +: AW];

    // operands during issue and readback selection otherwise
    assign rd_addr1_o       = issue_o ? pwdata_i[`CMD_VS1_LSB +: AW] : rdsel_q;
    assign rd_addr2_o       = issue_o ? pwdata_i[`CMD_VS2_LSB +: AW] : '0;
    assign rd_addr_old_vd_o = issue_o ? vd_o : '0;
    assign rd_addrm_o       = AW'(`VEC_MASK_REG);
    assign use_mask_o       = issue_o && pwdata_i[`CMD_USE_MASK_BIT];

    assign prdata_o = (access && !pwrite_i && rd_hit) ?
                      rd_data1_i[paddr_i[3:2]*APB_DATA_W +: APB_DATA_W] : '0;

endmodule

/* source/vec_pkg.sv */
// shared widths, width types and ALU op codes for the vector unit
package vec_pkg;

    // register and element geometry
    localparam int VLEN     = 128;
    localparam int ELEM_W   = 8;
    localparam int NUM_ELEM = VLEN / ELEM_W;

    // write-back ports: 0 is the ALU, 1 is host commit
    localparam int NUM_WB = 2;

    localparam int DEF_NUM_PREGS = 32;

    // bus width seen by the host
    localparam int APB_DATA_W = 32;

    typedef logic [VLEN-1:0]       vreg_data_t;   // one vector register
    typedef logic [NUM_ELEM-1:0]   vmask_t;       // one bit per element
    typedef logic [ELEM_W-1:0]     elem_t;
    typedef logic [APB_DATA_W-1:0] apb_word_t;

    typedef logic [1:0] alu_op_t;

    localparam alu_op_t OP_ADD = 2'd0;    // wraps modulo 256
    localparam alu_op_t OP_SUB = 2'd1;    // wraps modulo 256
    localparam alu_op_t OP_AND = 2'd2;
    localparam alu_op_t OP_XOR = 2'd3;

endpackage

/* source/vec_regfile.sv */
// physical vector register file, two write ports with bypass onto every read port
`timescale 1ns/100ps

module vec_regfile
    import vec_pkg::*;
#(
    parameter int  NUM_PREGS = DEF_NUM_PREGS,
    localparam int AW        = $clog2(NUM_PREGS)
) (
    input  logic                          clk_i,
    // write ports, higher index wins on a clash
    input  logic       [NUM_WB-1:0]         write_enable_i,
    input  logic       [NUM_WB-1:0][AW-1:0] write_addr_i,
    input  vreg_data_t [NUM_WB-1:0]         write_data_i,
    // read addresses
    input  logic       [AW-1:0]           read_addr1_i,
    input  logic       [AW-1:0]           read_addr2_i,
    input  logic       [AW-1:0]           read_addr_old_vd_i,
    input  logic       [AW-1:0]           read_addrm_i,
    input  logic                          use_mask_i,
    // read data
    output vreg_data_t                    read_data1_o,
    output vreg_data_t                    read_data2_o,
    output vreg_data_t                    read_data_old_vd_o,
    output vmask_t                        read_mask_o
);

    vreg_data_t regs [NUM_PREGS];   // no reset on storage
    vreg_data_t mask_reg_data;

    // stored value unless a port writes this address now, last port has priority
    function automatic vreg_data_t bypass_read(
        input logic       [AW-1:0]             addr,
        input vreg_data_t                      stored,
        input logic       [NUM_WB-1:0]         wen,
        input logic       [NUM_WB-1:0][AW-1:0] waddr,
        input vreg_data_t [NUM_WB-1:0]         wdata
    );
        vreg_data_t data;
        data = stored;
        for (int i = 0; i < NUM_WB; i++) begin
            if (wen[i] && (waddr[i] == addr)) begin
                data = wdata[i];
            end
        end
        return data;
    endfunction

    assign read_data1_o = bypass_read(read_addr1_i, regs[read_addr1_i],
                                      write_enable_i, write_addr_i, write_data_i);

    assign read_data2_o = bypass_read(read_addr2_i, regs[read_addr2_i],
                                      write_enable_i, write_addr_i, write_data_i);

    assign read_data_old_vd_o = bypass_read(read_addr_old_vd_i, regs[read_addr_old_vd_i],
                                            write_enable_i, write_addr_i, write_data_i);

    assign mask_reg_data = bypass_read(read_addrm_i, regs[read_addrm_i],
                                       write_enable_i, write_addr_i, write_data_i);

    // unmasked ops see every element enabled
    assign read_mask_o = use_mask_i ? mask_reg_data[NUM_ELEM-1:0] : '1;

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < NUM_WB; i++) begin
            if (write_enable_i[i]) begin
                regs[write_addr_i[i]] <= write_data_i[i];   // later port overrides
            end
        end
    end

endmodule

/* source/vec_unit_top.sv */
// vector execution slice top: APB controller, register file and ALU
`timescale 1ns/100ps

module vec_unit_top
    import vec_pkg::*;
#(
    parameter int  NUM_PREGS = DEF_NUM_PREGS,
    localparam int AW        = $clog2(NUM_PREGS)
) (
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  logic [7:0] paddr_i,
    input  apb_word_t pwdata_i,
    output apb_word_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o
);

    logic [AW-1:0] rd_addr1;
    logic [AW-1:0] rd_addr2;
    logic [AW-1:0] rd_addr_old_vd;
    logic [AW-1:0] rd_addrm;
    logic          use_mask;
    vreg_data_t    rd_data1;
    vreg_data_t    rd_data2;
    vreg_data_t    rd_data_old_vd;
    vmask_t        rd_mask;

    logic          commit_en;
    logic [AW-1:0] commit_addr;
    vreg_data_t    commit_data;

    logic          issue;
    alu_op_t       op;
    logic [AW-1:0] vd;

    logic          alu_wb_en;
    logic [AW-1:0] alu_wb_addr;
    vreg_data_t    alu_wb_data;

    vec_apb_ctrl #(.NUM_PREGS(NUM_PREGS)) u_ctrl (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .psel_i          (psel_i),
        .penable_i       (penable_i),
        .pwrite_i        (pwrite_i),
        .paddr_i         (paddr_i),
        .pwdata_i        (pwdata_i),
        .prdata_o        (prdata_o),
        .pready_o        (pready_o),
        .pslverr_o       (pslverr_o),
        .rd_addr1_o      (rd_addr1),
        .rd_addr2_o      (rd_addr2),
        .rd_addr_old_vd_o(rd_addr_old_vd),
        .rd_addrm_o      (rd_addrm),
        .use_mask_o      (use_mask),
        .rd_data1_i      (rd_data1),
        .commit_en_o     (commit_en),
        .commit_addr_o   (commit_addr),
        .commit_data_o   (commit_data),
        .issue_o         (issue),
        .op_o            (op),
        .vd_o            (vd)
    );

    // port 0 is the ALU, port 1 the host commit
    vec_regfile #(.NUM_PREGS(NUM_PREGS)) u_regfile (
        .clk_i             (clk_i),
        .write_enable_i    ({commit_en, alu_wb_en}),
        .write_addr_i      ({commit_addr, alu_wb_addr}),
        .write_data_i      ({commit_data, alu_wb_data}),
        .read_addr1_i      (rd_addr1),
        .read_addr2_i      (rd_addr2),
        .read_addr_old_vd_i(rd_addr_old_vd),
        .read_addrm_i      (rd_addrm),
        .use_mask_i        (use_mask),
        .read_data1_o      (rd_data1),
        .read_data2_o      (rd_data2),
        .read_data_old_vd_o(rd_data_old_vd),
        .read_mask_o       (rd_mask)
    );

    vec_alu #(.NUM_PREGS(NUM_PREGS)) u_alu (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .issue_i   (issue),
        .op_i      (op),
        .vd_i      (vd),
        .use_mask_i(use_mask),
        .src1_i    (rd_data1),
        .src2_i    (rd_data2),
        .old_vd_i  (rd_data_old_vd),
        .mask_i    (rd_mask),
        .wb_en_o   (alu_wb_en),
        .wb_addr_o (alu_wb_addr),
        .wb_data_o (alu_wb_data)
    );

endmodule

/* tb.f */
+incdir+include
source/vec_pkg.sv
source/vec_regfile.sv
source/vec_alu.sv
source/vec_apb_ctrl.sv
source/vec_unit_top.sv
test/tb_vec_unit.sv

/* test/tb_vec_unit.sv */
// testbench for the vector unit with APB stimulus, shadow register model and readback checks
`timescale 1ns/100ps

`include "vec_regmap.svh"

module tb_vec_unit
    import vec_pkg::*;
();

    localparam int NUM_PREGS      = 32;
    localparam int TIMEOUT_CYCLES = 4000;   // about three times the expected run length

    logic       clk_i;
    logic       rst_i;
    logic       psel_i;
    logic       penable_i;
    logic       pwrite_i;
    logic [7:0] paddr_i;
    apb_word_t  pwdata_i;
    apb_word_t  prdata_o;
    logic       pready_o;
    logic       pslverr_o;

    vreg_data_t  model [NUM_PREGS];   // shadow copy of the register file
    logic [31:0] rng_state;
    int          cycle_count;
    int          check_count;
    int          err_count;

    vec_unit_top #(.NUM_PREGS(NUM_PREGS)) u_dut (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .psel_i   (psel_i),
        .penable_i(penable_i),
        .pwrite_i (pwrite_i),
        .paddr_i  (paddr_i),
        .pwdata_i (pwdata_i),
        .prdata_o (prdata_o),
        .pready_o (pready_o),
        .pslverr_o(pslverr_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) cycle_count <= cycle_count + 1;

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic vreg_data_t rand_vreg();
        return {next_rand(), next_rand(), next_rand(), next_rand()};
    endfunction

    // expected result per element, masked-off lanes keep the old value
    function automatic vreg_data_t expected_result(input alu_op_t op, input vreg_data_t a,
                                                   input vreg_data_t b, input vreg_data_t old,
                                                   input vmask_t mask);
        vreg_data_t res;
        elem_t      x;
        elem_t      y;
        for (int e = 0; e < NUM_ELEM; e++) begin
            x = a[e*8 +: 8];
            y = b[e*8 +: 8];
            if (!mask[e]) begin
                res[e*8 +: 8] = old[e*8 +: 8];
            end else if (op == OP_ADD) begin
                res[e*8 +: 8] = 8'((int'(x) + int'(y)) % 256);
            end else if (op == OP_SUB) begin
                res[e*8 +: 8] = 8'((int'(x) - int'(y) + 256) % 256);
            end else if (op == OP_AND) begin
                res[e*8 +: 8] = x & y;
            end else begin
                res[e*8 +: 8] = x ^ y;
            end
        end
        return res;
    endfunction

    function automatic apb_word_t build_cmd(input logic [5:0] vd, input logic [5:0] vs1,
                                            input logic [5:0] vs2, input alu_op_t op,
                                            input logic use_mask);
        apb_word_t cmd;
        cmd = '0;
        cmd[`CMD_VD_LSB +: 6]    = vd;
        cmd[`CMD_VS1_LSB +: 6]   = vs1;
        cmd[`CMD_VS2_LSB +: 6]   = vs2;
        cmd[`CMD_OP_LSB +: 2]    = op;
        cmd[`CMD_USE_MASK_BIT]   = use_mask;
        return cmd;
    endfunction

    // setup then access; the bus stays in access until the next transfer starts
    task automatic bus_xfer(input logic wr, input logic [7:0] addr, input apb_word_t wdata,
                            output apb_word_t rdata, output logic err);
        @(negedge clk_i);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = wr;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(negedge clk_i);
        penable_i = 1'b1;
        #1;
        rdata = prdata_o;
        err   = pslverr_o;
        check_count++;
        assert (pready_o === 1'b1) else begin
            $display("ERROR @%0t: pready %b on access to 0x%02h, expected 1",
                     $time, pready_o, addr);
            err_count++;
        end
    endtask

    task automatic bus_idle();
        @(negedge clk_i);
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic bus_write(input logic [7:0] addr, input apb_word_t wdata);
        apb_word_t rdata;
        logic      err;
        bus_xfer(1'b1, addr, wdata, rdata, err);
        check_count++;
        assert (err === 1'b0) else begin
            $display("ERROR @%0t: pslverr on write to 0x%02h", $time, addr);
            err_count++;
        end
    endtask

    task automatic commit_reg(input logic [4:0] r, input vreg_data_t data);
        for (int w = 0; w < 4; w++) begin
            bus_write(8'(`REG_STAGE0 + 4*w), data[w*32 +: 32]);
        end
        bus_write(`REG_COMMIT, apb_word_t'(r));
        model[r] = data;
    endtask

    task automatic check_reg(input logic [4:0] r);
        apb_word_t rdata;
        logic      err;
        bus_write(`REG_RDSEL, apb_word_t'(r));
        for (int w = 0; w < 4; w++) begin
            bus_xfer(1'b0, 8'(`REG_READ0 + 4*w), '0, rdata, err);
            check_count++;
            assert (err === 1'b0 && rdata === model[r][w*32 +: 32]) else begin
                $display("ERROR @%0t: v%0d word %0d read %h err %b, expected %h",
                         $time, r, w, rdata, err, model[r][w*32 +: 32]);
                err_count++;
            end
        end
    endtask

    // model is updated in issue order, which the bypass makes equivalent
    task automatic issue_op(input logic [4:0] vd, input logic [4:0] vs1, input logic [4:0] vs2,
                            input alu_op_t op, input logic use_mask);
        vmask_t mask;
        mask = use_mask ? model[`VEC_MASK_REG][15:0] : '1;
        bus_write(`REG_CMD, build_cmd({1'b0, vd}, {1'b0, vs1}, {1'b0, vs2}, op, use_mask));
        model[vd] = expected_result(op, model[vs1], model[vs2], model[vd], mask);
    endtask

    task automatic expect_error(input logic wr, input logic [7:0] addr);
        apb_word_t rdata;
        logic      err;
        bus_xfer(wr, addr, next_rand(), rdata, err);
        check_count++;
        assert (err === 1'b1) else begin
            $display("ERROR @%0t: no pslverr on %s of 0x%02h",
                     $time, wr ? "write" : "read", addr);
            err_count++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        $display("test %0d %s: %s", num, name, (err_count == errs_before) ? "ok" : "failed");
    endtask

    initial begin
        int errs_before;
        rng_state   = 32'd39813;
        cycle_count = 0;
        check_count = 0;
        err_count   = 0;
        rst_i       = 1'b1;
        psel_i      = 1'b0;
        penable_i   = 1'b0;
        pwrite_i    = 1'b0;
        paddr_i     = '0;
        pwdata_i    = '0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        errs_before = err_count;
        for (int r = 0; r < NUM_PREGS; r++) begin
            commit_reg(5'(r), rand_vreg());
        end
        for (int r = 0; r < NUM_PREGS; r++) begin
            check_reg(5'(r));
        end
        bus_idle();
        report_test(1, "commit and readback", errs_before);

        errs_before = err_count;
        for (int round = 0; round < 4; round++) begin
            for (int op = 0; op < 4; op++) begin
                logic [4:0] vd;
                vd = 5'(next_rand());
                issue_op(vd, 5'(next_rand()), 5'(next_rand()), alu_op_t'(op), 1'b0);
                check_reg(vd);
            end
        end
        bus_idle();
        report_test(2, "unmasked ops", errs_before);

        errs_before = err_count;
        for (int round = 0; round < 4; round++) begin
            logic [4:0] vd;
            commit_reg(5'(`VEC_MASK_REG), rand_vreg());   // fresh mask in v0
            vd = 5'(next_rand());
            issue_op(vd, 5'(next_rand()), 5'(next_rand()), alu_op_t'(next_rand()), 1'b1);
            check_reg(vd);
        end
        bus_idle();
        report_test(3, "masked op", errs_before);

        errs_before = err_count;
        for (int round = 0; round < 4; round++) begin
            logic [4:0] va;
            logic [4:0] vb;
            va = 5'(next_rand());
            vb = 5'(next_rand());
            issue_op(va, 5'(next_rand()), 5'(next_rand()), alu_op_t'(next_rand()), 1'b0);
            issue_op(vb, va, 5'(next_rand()), alu_op_t'(next_rand()), 1'b0);   // next transfer
            check_reg(va);
            check_reg(vb);
        end
        bus_idle();
        report_test(4, "back-to-back dependency", errs_before);

        errs_before = err_count;
        expect_error(1'b0, 8'h30);        // unmapped
        expect_error(1'b1, 8'h3C);
        expect_error(1'b0, `REG_STAGE0);  // write only
        expect_error(1'b0, `REG_CMD);
        expect_error(1'b1, `REG_READ1);   // read only
        for (int r = 0; r < NUM_PREGS; r++) begin
            check_reg(5'(r));
        end
        bus_idle();
        report_test(5, "error response", errs_before);

        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
